// File: source/pti_pkg.sv
// Parallel port bridge definitions
`default_nettype none

package pti_pkg;

  // ========================================
  // queue depths and word geometry
  // ========================================

  // receive word queue depth
  localparam int rx_words = 4;
  // transmit word queue depth
  localparam int tx_words = 4;
  // bytes per 64-bit bus word
  localparam int word_bytes = 8;

  // pointer and lane index widths
  localparam int rx_ptr_w = $clog2(rx_words);
  localparam int tx_ptr_w = $clog2(tx_words);
  localparam int lane_w = $clog2(word_bytes);
  // word counts need one extra bit to hold the full value
  localparam int count_w = 3;

  // ========================================
  // state and register select encodings
  // ========================================

  // chip-side strobe sequencer
  typedef enum logic [2:0] {
    seq_idle,
    seq_oe_on,
    seq_rd_low,
    seq_capture,
    seq_wr_low
  } seq_state_e;

  // register select from bus address bits 4:3, value 3 reads as zero
  typedef enum logic [1:0] {
    reg_status = 2'd0,
    reg_count  = 2'd1,
    reg_data   = 2'd2
  } reg_sel_e;

  // ========================================
  // pin and bus bundles
  // ========================================

  // chip pins into the bridge
  typedef struct packed {
    logic       rxf_n;
    logic       txe_n;
    logic [7:0] dat;
  } ft_in_t;

  // chip pins out of the bridge
  typedef struct packed {
    logic       rd_n;
    logic       wr_n;
    logic       oe_n;
    logic       siwu_n;
    logic [7:0] dat;
  } ft_out_t;

  // wishbone request from the master
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic        cs;
    logic [31:0] adr;
    logic [63:0] dat;
  } wb_req_t;

endpackage

`default_nettype wire

// File: source/pti_rx_packer.sv
// Receive byte packer
`timescale 1ns/1ps
`default_nettype none

module pti_rx_packer import pti_pkg::*; (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  logic                push_i,
  input  logic [7:0]          byte_i,
  input  logic                pop_i,
  output logic [63:0]         head_o,
  output logic [count_w-1:0]  count_o,
  output logic                almost_full_o
);

  // ========================================
  // assembly of the word in progress
  // ========================================

  // next lane to fill, low byte first
  logic [lane_w-1:0]   byte_idx;
  // bytes gathered so far
  logic [63:0]         asm_word;
  // assembly word with the incoming byte merged in
  logic [63:0]         merged_word;

  // queue storage and bookkeeping
  logic [63:0]         mem [rx_words];
  logic [rx_ptr_w-1:0] wr_ptr;
  logic [rx_ptr_w-1:0] rd_ptr;
  logic [count_w-1:0]  count;

  logic                last_lane;
  logic                push_word;
  logic                pop_ok;

  always_comb begin
    merged_word = asm_word;
    merged_word[byte_idx*8 +: 8] = byte_i;
  end

  assign last_lane = (byte_idx == lane_w'(word_bytes - 1));
  // eighth byte completes a word, dropped only if the queue were full
  assign push_word = push_i && last_lane && (count != count_w'(rx_words));
  // pop on an empty queue is ignored
  assign pop_ok = pop_i && (count != '0);

  // assembly register holds payload only
  always_ff @(posedge wb_clk_i) begin
    if (push_i) begin
      asm_word <= merged_word;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      byte_idx <= '0;
    end else if (push_i) begin
      // lane index wraps after the eighth byte
      byte_idx <= last_lane ? '0 : byte_idx + 1'b1;
    end
  end

  // ========================================
  // circular word queue
  // ========================================

  always_ff @(posedge wb_clk_i) begin
    if (push_word) begin
      mem[wr_ptr] <= merged_word;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_word) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_word, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head word visible without delay
  assign head_o = mem[rd_ptr];
  assign count_o = count;
  // one slot kept spare so a word in flight always has room
  assign almost_full_o = (count >= count_w'(rx_words - 1));

endmodule

`default_nettype wire

// File: source/pti_tx_unpacker.sv
// Transmit word unpacker
`timescale 1ns/1ps
`default_nettype none

module pti_tx_unpacker import pti_pkg::*; (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  logic                push_i,
  input  logic [63:0]         word_i,
  input  logic                pop_i,
  output logic [7:0]          byte_o,
  output logic                byte_valid_o,
  output logic [count_w-1:0]  count_o,
  output logic                almost_full_o
);

  // ========================================
  // word queue
  // ========================================

  logic [63:0]         mem [tx_words];
  logic [tx_ptr_w-1:0] wr_ptr;
  logic [tx_ptr_w-1:0] rd_ptr;
  logic [count_w-1:0]  count;

  // lane of the head word to send next
  logic [lane_w-1:0]   byte_idx;
  logic [63:0]         head_word;

  logic                push_ok;
  logic                pop_ok;
  logic                last_lane;
  logic                free_word;

  assign push_ok = push_i && (count != count_w'(tx_words));
  assign pop_ok = pop_i && byte_valid_o;
  assign last_lane = (byte_idx == lane_w'(word_bytes - 1));
  // the eighth byte out releases the head word
  assign free_word = pop_ok && last_lane;

  always_ff @(posedge wb_clk_i) begin
    if (push_ok) begin
      mem[wr_ptr] <= word_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      byte_idx <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        byte_idx <= last_lane ? '0 : byte_idx + 1'b1;
      end
      if (free_word) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_ok, free_word})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ========================================
  // byte output
  // ========================================

  assign head_word = mem[rd_ptr];
  // low lane first
  assign byte_o = head_word[byte_idx*8 +: 8];
  assign byte_valid_o = (count != '0);

  assign count_o = count;
  // bus writes stall here
  assign almost_full_o = (count >= count_w'(tx_words - 1));

endmodule

`default_nettype wire

// File: source/pti_port_sequencer.sv
// Chip strobe sequencer
`timescale 1ns/1ps
`default_nettype none

module pti_port_sequencer import pti_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        rst_i,
  input  ft_in_t      ft_i,
  output ft_out_t     ft_o,
  output logic        rx_push_o,
  output logic [7:0]  rx_byte_o,
  input  logic        rx_almost_full_i,
  input  logic [7:0]  tx_byte_i,
  input  logic        tx_byte_valid_i,
  output logic        tx_pop_o
);

  seq_state_e state;

  // registered strobes, all active low
  logic       rd_n_q;
  logic       wr_n_q;
  logic       oe_n_q;
  // byte driven to the chip
  logic [7:0] dat_q;

  logic       start_rd;
  logic       start_wr;

  // ========================================
  // transfer start decision
  // ========================================

  // receive wins when both sides are ready
  assign start_rd = (state == seq_idle) && !ft_i.rxf_n && !rx_almost_full_i;
  assign start_wr = (state == seq_idle) && !start_rd && !ft_i.txe_n && tx_byte_valid_i;

  // byte leaves the unpacker on the edge that lowers wr_n
  assign tx_pop_o = start_wr;

  // ========================================
  // state machine
  // ========================================

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      state     <= seq_idle;
      rd_n_q    <= 1'b1;
      wr_n_q    <= 1'b1;
      oe_n_q    <= 1'b1;
      rx_push_o <= 1'b0;
    end else begin
      // single cycle pulses by default
      rd_n_q    <= 1'b1;
      wr_n_q    <= 1'b1;
      rx_push_o <= 1'b0;
      case (state)
        seq_idle: begin
          if (start_rd) begin
            // enable chip output drivers first
            oe_n_q <= 1'b0;
            state  <= seq_oe_on;
          end else if (start_wr) begin
            wr_n_q <= 1'b0;
            state  <= seq_wr_low;
          end
        end
        seq_oe_on: begin
          rd_n_q <= 1'b0;
          state  <= seq_rd_low;
        end
        seq_rd_low: begin
          // byte is sampled as rd_n rises
          rx_push_o <= 1'b1;
          state     <= seq_capture;
        end
        seq_capture: begin
          oe_n_q <= 1'b1;
          state  <= seq_idle;
        end
        seq_wr_low: begin
          state <= seq_idle;
        end
        default: begin
          oe_n_q <= 1'b1;
          state  <= seq_idle;
        end
      endcase
    end
  end

  // data registers carry payload only
  always_ff @(posedge wb_clk_i) begin
    if (state == seq_rd_low) begin
      rx_byte_o <= ft_i.dat;
    end
    if (start_wr) begin
      dat_q <= tx_byte_i;
    end
  end

  assign ft_o.rd_n = rd_n_q;
  assign ft_o.wr_n = wr_n_q;
  assign ft_o.oe_n = oe_n_q;
  // send-immediate is never used
  assign ft_o.siwu_n = 1'b1;
  assign ft_o.dat = dat_q;

endmodule

`default_nettype wire

// File: source/pti_wb_slave.sv
// Wishbone register slave
`timescale 1ns/1ps
`default_nettype none

module pti_wb_slave import pti_pkg::*; (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  wb_req_t             wb_i,
  output logic                wb_ack_o,
  output logic [63:0]         wb_dat_o,
  output logic                tx_push_o,
  output logic [63:0]         tx_word_o,
  input  logic                tx_almost_full_i,
  input  logic [count_w-1:0]  tx_count_i,
  output logic                rx_pop_o,
  input  logic [63:0]         rx_head_i,
  input  logic [count_w-1:0]  rx_count_i,
  input  logic                rx_almost_full_i
);

  reg_sel_e    sel;
  logic        req;
  // set once the held request has acted
  logic        done;
  logic        ack_q;
  logic        accept_wr;
  logic        accept_rd;
  logic [63:0] rd_mux;

  // ========================================
  // request decode
  // ========================================

  assign req = wb_i.cs && wb_i.cyc && wb_i.stb;
  assign sel = reg_sel_e'(wb_i.adr[4:3]);

  // writes wait while the transmit queue is almost full
  assign accept_wr = req && wb_i.we && !done && !tx_almost_full_i;
  // reads never stall
  assign accept_rd = req && !wb_i.we && !done;

  assign tx_push_o = accept_wr;
  assign tx_word_o = wb_i.dat;
  // only a data read consumes a receive word
  assign rx_pop_o = accept_rd && (sel == reg_data);

  // read data select
  always_comb begin
    case (sel)
      reg_status: rd_mux = {53'd0, tx_count_i, 6'd0, tx_almost_full_i, rx_almost_full_i};
      reg_count:  rd_mux = {61'd0, rx_count_i};
      reg_data:   rd_mux = rx_head_i;
      default:    rd_mux = 64'd0;
    endcase
  end

  // ========================================
  // ack and read data registers
  // ========================================

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      done  <= 1'b0;
      ack_q <= 1'b0;
    end else if (!req) begin
      // request ended, ready for the next one
      done  <= 1'b0;
      ack_q <= 1'b0;
    end else if (accept_wr || accept_rd) begin
      done  <= 1'b1;
      ack_q <= 1'b1;
    end
  end

  // head word is captured before the pop moves the pointer
  always_ff @(posedge wb_clk_i) begin
    if (accept_rd) begin
      wb_dat_o <= rd_mux;
    end
  end

  // ack drops as soon as stb or cyc goes away
  assign wb_ack_o = ack_q && req;

endmodule

`default_nettype wire

// File: source/pti_top.sv
// Parallel port bridge top
`timescale 1ns/1ps
`default_nettype none

module pti_top import pti_pkg::*; (
  input  logic         wb_clk_i,
  input  logic         rst_i,
  input  ft_in_t       ft_i,
  output ft_out_t      ft_o,
  input  wb_req_t      wb_i,
  output logic         wb_ack_o,
  output logic [63:0]  wb_dat_o
);

  // chip to bus path
  logic               rx_push;
  logic [7:0]         rx_byte;
  logic               rx_pop;
  logic [63:0]        rx_head;
  logic [count_w-1:0] rx_count;
  logic               rx_almost_full;

  // bus to chip path
  logic               tx_push;
  logic [63:0]        tx_word;
  logic               tx_pop;
  logic [7:0]         tx_byte;
  logic               tx_byte_valid;
  logic [count_w-1:0] tx_count;
  logic               tx_almost_full;

  // ========================================
  // chip side
  // ========================================

  pti_port_sequencer pti_port_sequencer_inst (
    .wb_clk_i         (wb_clk_i),
    .rst_i            (rst_i),
    .ft_i             (ft_i),
    .ft_o             (ft_o),
    .rx_push_o        (rx_push),
    .rx_byte_o        (rx_byte),
    .rx_almost_full_i (rx_almost_full),
    .tx_byte_i        (tx_byte),
    .tx_byte_valid_i  (tx_byte_valid),
    .tx_pop_o         (tx_pop)
  );

  // ========================================
  // word queues
  // ========================================

  pti_rx_packer pti_rx_packer_inst (
    .wb_clk_i      (wb_clk_i),
    .rst_i         (rst_i),
    .push_i        (rx_push),
    .byte_i        (rx_byte),
    .pop_i         (rx_pop),
    .head_o        (rx_head),
    .count_o       (rx_count),
    .almost_full_o (rx_almost_full)
  );

  pti_tx_unpacker pti_tx_unpacker_inst (
    .wb_clk_i      (wb_clk_i),
    .rst_i         (rst_i),
    .push_i        (tx_push),
    .word_i        (tx_word),
    .pop_i         (tx_pop),
    .byte_o        (tx_byte),
    .byte_valid_o  (tx_byte_valid),
    .count_o       (tx_count),
    .almost_full_o (tx_almost_full)
  );

  // ========================================
  // bus side
  // ========================================

  pti_wb_slave pti_wb_slave_inst (
    .wb_clk_i         (wb_clk_i),
    .rst_i            (rst_i),
    .wb_i             (wb_i),
    .wb_ack_o         (wb_ack_o),
    .wb_dat_o         (wb_dat_o),
    .tx_push_o        (tx_push),
    .tx_word_o        (tx_word),
    .tx_almost_full_i (tx_almost_full),
    .tx_count_i       (tx_count),
    .rx_pop_o         (rx_pop),
    .rx_head_i        (rx_head),
    .rx_count_i       (rx_count),
    .rx_almost_full_i (rx_almost_full)
  );

endmodule

`default_nettype wire

// File: testbench/pti_assertions.sv
// Bridge protocol checker
`timescale 1ns/1ps
`default_nettype none

module pti_assertions import pti_pkg::*; (
  input logic    wb_clk_i,
  input logic    rst_i,
  input ft_out_t ft_o,
  input wb_req_t wb_i,
  input logic    wb_ack_o
);

  // failure tally, read by the testbench at the end of the run
  int assert_fails = 0;

  // ========================================
  // chip pin rules
  // ========================================

  // a read and a write never overlap on the shared data pins
  strobes_exclusive: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    !(!ft_o.rd_n && !ft_o.wr_n))
    else begin
      $error("rd_n and wr_n are low in the same cycle");
      assert_fails++;
    end

  // chip output drivers are enabled before and during the read strobe
  rd_needs_oe: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    !ft_o.rd_n |-> !ft_o.oe_n)
    else begin
      $error("rd_n is low while oe_n is high");
      assert_fails++;
    end

  // send-immediate stays inactive
  siwu_idle: assert property (@(posedge wb_clk_i) disable iff (rst_i) ft_o.siwu_n)
    else begin
      $error("siwu_n went low");
      assert_fails++;
    end

  // ========================================
  // bus rule
  // ========================================

  // ack only inside a live cycle
  ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    wb_ack_o |-> (wb_i.cyc && wb_i.stb))
    else begin
      $error("ack is high without cyc and stb");
      assert_fails++;
    end

endmodule

`default_nettype wire

// File: testbench/pti_tb.sv
// Port bridge testbench
`timescale 1ns/1ps
`default_nettype none

module pti_tb import pti_pkg::*;;

  typedef logic [7:0] byte_q_t[$];

  // 4 cycles per received byte, about 60 received and 60 sent bytes,
  // bus polling and two 50 cycle waits, then a wide margin
  localparam int timeout_cycles = 6000;
  // longest wait for a single ack
  localparam int ack_limit = 400;

  logic        wb_clk_i;
  logic        rst_i;
  ft_in_t      ft_i;
  ft_out_t     ft_o;
  wb_req_t     wb_i;
  logic        wb_ack_o;
  logic [63:0] wb_dat_o;

  // chip model state
  byte_q_t     rx_bytes;
  byte_q_t     tx_got;
  byte_q_t     tx_exp;
  logic        tx_en;
  logic        rd_active;
  int          tx_checked;

  // bookkeeping
  int unsigned lcg_state = 32'd74513;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_err0;
  int          cycles;
  string       cur_test;
  byte_q_t     sent;

  pti_top pti_top_inst (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .ft_i     (ft_i),
    .ft_o     (ft_o),
    .wb_i     (wb_i),
    .wb_ack_o (wb_ack_o),
    .wb_dat_o (wb_dat_o)
  );

  bind pti_top pti_assertions pti_assertions_inst (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .ft_o     (ft_o),
    .wb_i     (wb_i),
    .wb_ack_o (wb_ack_o)
  );

  // ========================================
  // clock, random bytes, reference
  // ========================================

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // eight bytes from base, low lane first
  function automatic logic [63:0] expect_word(input byte_q_t b, input int base);
    logic [63:0] w;
    int          k;
    w = '0;
    for (k = 0; k < word_bytes; k++) begin
      w[k*8 +: 8] = b[base+k];
    end
    return w;
  endfunction

  // ========================================
  // compare tasks
  // ========================================

  task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected 0x%016h, actual 0x%016h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input logic [count_w-1:0] exp,
                             input logic [count_w-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // ========================================
  // chip model and byte compare
  // ========================================

  // chip pins sampled 2 ns after each edge where the registered strobes have settled
  initial begin
    ft_i.rxf_n = 1'b1;
    ft_i.txe_n = 1'b1;
    ft_i.dat   = 8'h00;
    rd_active  = 1'b0;
    forever begin
      @(posedge wb_clk_i);
      #2;
      // rd_n rising ends the read and the chip moves on to its next byte
      if (!ft_o.rd_n) begin
        rd_active = 1'b1;
      end else if (rd_active) begin
        rd_active = 1'b0;
        void'(rx_bytes.pop_front());
      end
      if (!ft_o.wr_n && tx_en) begin
        tx_got.push_back(ft_o.dat);
      end
      ft_i.txe_n = !tx_en;
      ft_i.rxf_n = (rx_bytes.size() == 0);
      ft_i.dat   = (!ft_o.rd_n && rx_bytes.size() != 0) ? rx_bytes[0] : 8'h00;
    end
  end

  // bytes seen by the chip against the expected lane order
  initial begin
    logic [7:0] got_b;
    tx_checked = 0;
    forever begin
      @(posedge wb_clk_i);
      #3;
      while (tx_got.size() != 0) begin
        got_b = tx_got.pop_front();
        if (tx_exp.size() == 0) begin
          errors++;
          $display("%s: chip received byte 0x%02h when none was expected", cur_test, got_b);
        end else begin
          check_byte({cur_test, " chip byte"}, tx_exp.pop_front(), got_b);
        end
        tx_checked++;
      end
    end
  end

  // ========================================
  // bus tasks
  // ========================================

  task automatic next_cycle();
    @(posedge wb_clk_i);
    #2;
  endtask

  task automatic bus_start(input logic we, input logic [1:0] sel, input logic [63:0] data);
    wb_i.cyc = 1'b1;
    wb_i.stb = 1'b1;
    wb_i.cs  = 1'b1;
    wb_i.we  = we;
    wb_i.adr = {27'd0, sel, 3'd0};
    wb_i.dat = data;
  endtask

  // waits for ack, ends the request on ack and leaves one idle cycle
  task automatic bus_wait(input int limit, output logic got, output logic [63:0] rdata);
    int i;
    got   = 1'b0;
    rdata = '0;
    for (i = 0; i < limit && !got; i++) begin
      next_cycle();
      if (wb_ack_o) begin
        got   = 1'b1;
        rdata = wb_dat_o;
      end
    end
    if (got) begin
      wb_i = '0;
      next_cycle();
    end
  endtask

  task automatic bus_write(input logic [63:0] data);
    logic        got;
    logic [63:0] unused;
    bus_start(1'b1, reg_data, data);
    bus_wait(ack_limit, got, unused);
    if (!got) begin
      errors++;
      $display("%s: write was never acknowledged", cur_test);
    end
  endtask

  task automatic bus_read(input logic [1:0] sel, output logic [63:0] data);
    logic got;
    bus_start(1'b0, sel, '0);
    bus_wait(ack_limit, got, data);
    if (!got) begin
      errors++;
      $display("%s: read was never acknowledged", cur_test);
    end
  endtask

  // polls reg_count until it reaches the target
  task automatic wait_count(input int target);
    logic [63:0] d;
    bus_read(reg_count, d);
    while (d < target) begin
      bus_read(reg_count, d);
    end
  endtask

  task automatic write_random_word();
    logic [63:0] w;
    int          k;
    for (k = 0; k < word_bytes; k++) begin
      w[k*8 +: 8] = lcg_byte();
    end
    for (k = 0; k < word_bytes; k++) begin
      tx_exp.push_back(w[k*8 +: 8]);
    end
    bus_write(w);
  endtask

  task automatic queue_rx_bytes(input int n);
    int k;
    logic [7:0] b;
    sent.delete();
    for (k = 0; k < n; k++) begin
      b = lcg_byte();
      sent.push_back(b);
      rx_bytes.push_back(b);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_err0) begin
      tests_failed++;
    end
    $display("test %s: done, %0d errors", cur_test, errors - test_err0);
  endtask

  // ========================================
  // run limit
  // ========================================

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge wb_clk_i);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Test failures found");
    $finish;
  end

  // ========================================
  // tests
  // ========================================

  initial begin
    logic [63:0] d;
    logic        got;
    int          base;
    int          w;
    rst_i = 1'b1;
    wb_i  = '0;
    tx_en = 1'b0;
    repeat (16) @(posedge wb_clk_i);
    #2;
    rst_i = 1'b0;
    next_cycle();

    begin_test("reset_state");
    check_flag("rd_n after reset", 1'b1, ft_o.rd_n);
    check_flag("wr_n after reset", 1'b1, ft_o.wr_n);
    check_flag("oe_n after reset", 1'b1, ft_o.oe_n);
    check_flag("siwu_n after reset", 1'b1, ft_o.siwu_n);
    check_flag("ack after reset", 1'b0, wb_ack_o);
    bus_read(reg_count, d);
    check_count("reg_count after reset", '0, d[count_w-1:0]);
    bus_read(reg_status, d);
    check_word("reg_status after reset", 64'd0, d);
    end_test();

    begin_test("rx_packing");
    queue_rx_bytes(16);
    wait_count(2);
    bus_read(reg_data, d);
    check_word("rx word 0", expect_word(sent, 0), d);
    bus_read(reg_data, d);
    check_word("rx word 1", expect_word(sent, 8), d);
    end_test();

    begin_test("tx_unpacking");
    tx_en = 1'b1;
    base  = tx_checked;
    repeat (3) write_random_word();
    while (tx_checked < base + 24) next_cycle();
    // no extra bytes once the queue has drained
    repeat (4) next_cycle();
    check_word("chip bytes received", 64'(base + 24), 64'(tx_checked));
    end_test();

    begin_test("tx_backpressure");
    tx_en = 1'b0;
    next_cycle();
    base = tx_checked;
    repeat (3) write_random_word();
    bus_read(reg_status, d);
    check_flag("status tx almost full", 1'b1, d[1]);
    check_count("status tx count", count_w'(3), d[8 +: count_w]);
    // fourth word waits for space
    d = {lcg_byte(), lcg_byte(), lcg_byte(), lcg_byte(),
         lcg_byte(), lcg_byte(), lcg_byte(), lcg_byte()};
    for (w = 0; w < word_bytes; w++) begin
      tx_exp.push_back(d[w*8 +: 8]);
    end
    bus_start(1'b1, reg_data, d);
    bus_wait(50, got, d);
    if (got) begin
      errors++;
      $display("%s: fourth write was acknowledged while the queue was almost full", cur_test);
    end
    tx_en = 1'b1;
    bus_wait(ack_limit, got, d);
    if (!got) begin
      errors++;
      $display("%s: fourth write never completed after txe_n was released", cur_test);
    end
    while (tx_checked < base + 32) next_cycle();
    repeat (4) next_cycle();
    check_word("chip bytes received", 64'(base + 32), 64'(tx_checked));
    end_test();

    begin_test("rx_flow_control");
    queue_rx_bytes(40);
    wait_count(3);
    bus_read(reg_status, d);
    check_flag("status rx almost full", 1'b1, d[0]);
    repeat (50) next_cycle();
    // three words taken and 16 bytes left in the chip
    check_word("bytes held by chip", 64'd16, rx_bytes.size());
    for (w = 0; w < 5; w++) begin
      wait_count(1);
      bus_read(reg_data, d);
      check_word($sformatf("rx word %0d", w), expect_word(sent, w * word_bytes), d);
    end
    check_word("bytes held by chip", 64'd0, rx_bytes.size());
    end_test();

    begin_test("unused_register");
    bus_read(2'd3, d);
    check_word("select 3 read", 64'd0, d);
    end_test();

    errors += pti_top_inst.pti_assertions_inst.assert_fails;
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
source/pti_pkg.sv
source/pti_rx_packer.sv
source/pti_tx_unpacker.sv
source/pti_port_sequencer.sv
source/pti_wb_slave.sv
source/pti_top.sv
testbench/pti_assertions.sv
testbench/pti_tb.sv
